// File: design/periph_settings.svh
// ******************************
// Peripheral subsystem settings
// Bus widths, pin count, timer count
// and the address map fields
// ******************************

`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

`define WB_ADR_W 16
`define WB_DAT_W 32
`define GPIO_W 32
`define PWM_NUM 3

// Address map fields and mapped slot count
`define SLOT_LSB 8
`define SLOT_W 3
`define SLOT_NUM 5
`define REG_LSB 2
`define REG_W 3

`endif

// File: design/wb_pkg.sv
// ******************************
// Register bus types
// Address, data and slot numbers
// ******************************

`include "periph_settings.svh"

package wb_pkg;

   typedef logic [`WB_ADR_W-1:0] wb_adr_t;
   typedef logic [`WB_DAT_W-1:0] wb_data_t;

   // Peripheral slots with 5 to 7 left unmapped
   typedef enum logic [`SLOT_W-1:0] {
      SLOT_GPIO0 = 3'd0,
      SLOT_GPIO1 = 3'd1,
      SLOT_PWM0  = 3'd2,
      SLOT_PWM1  = 3'd3,
      SLOT_PWM2  = 3'd4
   } wb_slot_e;

endpackage

// File: design/periph_pkg.sv
// ******************************
// Peripheral register map types
// GPIO and PWM timer offsets
// ******************************

`include "periph_settings.svh"

package periph_pkg;

   typedef logic [`GPIO_W-1:0] gpio_word_t;

   typedef enum logic [`REG_W-1:0] {
      GPIO_IN    = 3'd0,
      GPIO_OUT   = 3'd1,
      GPIO_OE    = 3'd2,
      GPIO_INTE  = 3'd3,
      GPIO_ISTAT = 3'd4
   } gpio_reg_e;

   typedef enum logic [`REG_W-1:0] {
      PWM_CNTR = 3'd0,
      PWM_HRC  = 3'd1,
      PWM_LRC  = 3'd2,
      PWM_CTRL = 3'd3
   } pwm_reg_e;

   // Timer control bits
   localparam int PWM_CTRL_EN   = 0;
   localparam int PWM_CTRL_OE   = 1;
   localparam int PWM_CTRL_INTE = 2;
   localparam int PWM_CTRL_INT  = 3;

endpackage

// File: design/wb_if.sv
// ******************************
// Decoder to peripheral bus
// One slot of the register bus
// ******************************

`timescale 1ns/1ns
`include "periph_settings.svh"

interface wb_if;
   import wb_pkg::*;

   logic [`REG_W-1:0] adr;
   wb_data_t          dat_w;
   logic              we;
   logic              stb;
   wb_data_t          dat_r;
   logic              ack;

   modport master (
      output adr, dat_w, we, stb,
      input  dat_r, ack
   );

   modport slave (
      input  adr, dat_w, we, stb,
      output dat_r, ack
   );

endinterface

// File: design/wb_decoder.sv
// ******************************
// Register bus slot decoder
// Routes the strobe to one slot, muxes
// read data and acks unmapped accesses
// ******************************

`timescale 1ns/1ns
`include "periph_settings.svh"

module wb_decoder (
   input  logic             clk,
   input  logic             i_arst_n,
   input  wb_pkg::wb_adr_t  i_wb_adr,
   input  wb_pkg::wb_data_t i_wb_dat,
   input  logic             i_wb_we,
   input  logic             i_wb_stb,
   output wb_pkg::wb_data_t o_wb_rdt,
   output logic             o_wb_ack,
   output logic             o_wb_err,
   wb_if.master             m_slot [`SLOT_NUM]
);
   import wb_pkg::*;

   wb_slot_e             slot;
   logic [`REG_W-1:0]    reg_ofs;
   logic                 unmapped;
   logic                 err_stb_q;
   logic                 err_ack_q;
   logic [`SLOT_NUM-1:0] slot_ack;
   wb_data_t             slot_rdt [`SLOT_NUM];

   assign slot     = wb_slot_e'(i_wb_adr[`SLOT_LSB +: `SLOT_W]);
   assign reg_ofs  = i_wb_adr[`REG_LSB +: `REG_W];
   assign unmapped = (int'(slot) >= `SLOT_NUM);

   // ******************************
   // Slot fan-out
   // ******************************
   for (genvar i = 0; i < `SLOT_NUM; i++) begin : g_slot
      assign m_slot[i].adr   = reg_ofs;
      assign m_slot[i].dat_w = i_wb_dat;
      assign m_slot[i].we    = i_wb_we;
      assign m_slot[i].stb   = i_wb_stb && (int'(slot) == i);
      assign slot_ack[i]     = m_slot[i].ack;
      assign slot_rdt[i]     = m_slot[i].dat_r;
   end

   // One error ack per strobe
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         err_stb_q <= 1'b0;
         err_ack_q <= 1'b0;
      end else begin
         err_stb_q <= i_wb_stb && unmapped;
         err_ack_q <= i_wb_stb && unmapped && !err_stb_q;
      end
   end

   // ******************************
   // Response mux
   // ******************************
   always_comb begin
      o_wb_rdt = '0;
      o_wb_ack = err_ack_q;
      for (int i = 0; i < `SLOT_NUM; i++) begin
         if (int'(slot) == i) begin
            o_wb_rdt = slot_rdt[i];
            o_wb_ack = slot_ack[i];
         end
      end
   end

   assign o_wb_err = err_ack_q;

endmodule

// File: design/gpio_bank.sv
// ******************************
// GPIO bank
// Synchronized inputs, output and enable
// registers, rising edge interrupt
// ******************************

`timescale 1ns/1ns

module gpio_bank (
   input  logic                   clk,
   input  logic                   i_arst_n,
   wb_if.slave                    s_bus,
   input  periph_pkg::gpio_word_t i_pins,
   output periph_pkg::gpio_word_t o_out,
   output periph_pkg::gpio_word_t o_oe,
   output logic                   o_irq
);
   import wb_pkg::*;
   import periph_pkg::*;

   gpio_word_t sync_q;
   gpio_word_t pins_q;
   gpio_word_t pins_prev_q;
   gpio_word_t out_q;
   gpio_word_t oe_q;
   gpio_word_t inte_q;
   gpio_word_t istat_q;
   gpio_word_t rise;
   gpio_word_t clr;
   logic       stb_q;
   logic       ack_q;
   logic       req;
   logic       wr;
   gpio_reg_e  reg_sel;
   wb_data_t   rd_data;
   wb_data_t   rdt_q;

   // First cycle of a strobe only
   assign req     = s_bus.stb && !stb_q;
   assign wr      = req && s_bus.we;
   assign reg_sel = gpio_reg_e'(s_bus.adr);
   assign rise    = pins_q & ~pins_prev_q & inte_q;
   assign clr     = (wr && reg_sel == GPIO_ISTAT) ? gpio_word_t'(s_bus.dat_w) : '0;

   // ******************************
   // Input synchronizer
   // ******************************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         sync_q      <= '0;
         pins_q      <= '0;
         pins_prev_q <= '0;
      end else begin
         sync_q      <= i_pins;
         pins_q      <= sync_q;
         pins_prev_q <= pins_q;
      end
   end

   // ******************************
   // Registers
   // ******************************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         stb_q   <= 1'b0;
         ack_q   <= 1'b0;
         out_q   <= '0;
         oe_q    <= '0;
         inte_q  <= '0;
         istat_q <= '0;
      end else begin
         stb_q   <= s_bus.stb;
         ack_q   <= req;
         // A new edge wins over a clear in the same cycle
         istat_q <= (istat_q & ~clr) | rise;
         if (wr) begin
            case (reg_sel)
               GPIO_OUT:  out_q  <= gpio_word_t'(s_bus.dat_w);
               GPIO_OE:   oe_q   <= gpio_word_t'(s_bus.dat_w);
               GPIO_INTE: inte_q <= gpio_word_t'(s_bus.dat_w);
               default: ;
            endcase
         end
      end
   end

   always_comb begin
      case (reg_sel)
         GPIO_IN:    rd_data = wb_data_t'(pins_q);
         GPIO_OUT:   rd_data = wb_data_t'(out_q);
         GPIO_OE:    rd_data = wb_data_t'(oe_q);
         GPIO_INTE:  rd_data = wb_data_t'(inte_q);
         GPIO_ISTAT: rd_data = wb_data_t'(istat_q);
         default:    rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (req) begin
         rdt_q <= rd_data;
      end
   end

   assign s_bus.dat_r = rdt_q;
   assign s_bus.ack   = ack_q;
   assign o_out       = out_q;
   assign o_oe        = oe_q;
   assign o_irq       = |istat_q;

endmodule

// File: design/pwm_timer.sv
// ******************************
// PWM timer
// Free running counter with period and
// duty compare, wrap interrupt
// ******************************

`timescale 1ns/1ns

module pwm_timer (
   input  logic clk,
   input  logic i_arst_n,
   wb_if.slave  s_bus,
   output logic o_pwm,
   output logic o_irq
);
   import wb_pkg::*;
   import periph_pkg::*;

   wb_data_t              cntr_q;
   wb_data_t              cntr_nxt;
   wb_data_t              hrc_q;
   wb_data_t              lrc_q;
   logic [PWM_CTRL_INT:0] ctrl_q;
   logic                  pwm_q;
   logic                  en;
   logic                  wrap;
   logic                  stb_q;
   logic                  ack_q;
   logic                  req;
   logic                  wr;
   logic                  int_clr;
   pwm_reg_e              reg_sel;
   wb_data_t              rd_data;
   wb_data_t              rdt_q;

   assign req      = s_bus.stb && !stb_q;
   assign wr       = req && s_bus.we;
   assign reg_sel  = pwm_reg_e'(s_bus.adr);
   assign int_clr  = wr && reg_sel == PWM_CTRL && !s_bus.dat_w[PWM_CTRL_INT];

   assign en       = ctrl_q[PWM_CTRL_EN];
   assign wrap     = en && (cntr_q == lrc_q);
   assign cntr_nxt = wrap ? '0 : cntr_q + wb_data_t'(1);

   // ******************************
   // Counter and output
   // ******************************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         cntr_q <= '0;
         pwm_q  <= 1'b0;
      end else begin
         if (wr && reg_sel == PWM_CNTR) begin
            cntr_q <= s_bus.dat_w;
         end else if (en) begin
            cntr_q <= cntr_nxt;
         end
         // High from the cycle the count reaches HRC up to LRC
         if (wrap) begin
            pwm_q <= 1'b0;
         end else if (en && cntr_nxt == hrc_q) begin
            pwm_q <= 1'b1;
         end
      end
   end

   // ******************************
   // Registers
   // ******************************
   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         stb_q  <= 1'b0;
         ack_q  <= 1'b0;
         hrc_q  <= '0;
         lrc_q  <= '0;
         ctrl_q <= '0;
      end else begin
         stb_q <= s_bus.stb;
         ack_q <= req;
         if (wr) begin
            case (reg_sel)
               PWM_HRC: hrc_q <= s_bus.dat_w;
               PWM_LRC: lrc_q <= s_bus.dat_w;
               PWM_CTRL: begin
                  ctrl_q[PWM_CTRL_EN]   <= s_bus.dat_w[PWM_CTRL_EN];
                  ctrl_q[PWM_CTRL_OE]   <= s_bus.dat_w[PWM_CTRL_OE];
                  ctrl_q[PWM_CTRL_INTE] <= s_bus.dat_w[PWM_CTRL_INTE];
               end
               default: ;
            endcase
         end
         // Software can only clear the flag
         if (wrap && ctrl_q[PWM_CTRL_INTE]) begin
            ctrl_q[PWM_CTRL_INT] <= 1'b1;
         end else if (int_clr) begin
            ctrl_q[PWM_CTRL_INT] <= 1'b0;
         end
      end
   end

   always_comb begin
      case (reg_sel)
         PWM_CNTR: rd_data = cntr_q;
         PWM_HRC:  rd_data = hrc_q;
         PWM_LRC:  rd_data = lrc_q;
         PWM_CTRL: rd_data = wb_data_t'(ctrl_q);
         default:  rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (req) begin
         rdt_q <= rd_data;
      end
   end

   assign s_bus.dat_r = rdt_q;
   assign s_bus.ack   = ack_q;
   assign o_pwm       = pwm_q && ctrl_q[PWM_CTRL_OE];
   assign o_irq       = ctrl_q[PWM_CTRL_INT];

endmodule

// File: design/periph_top.sv
// ******************************
// Peripheral subsystem top
// Bus decoder, two GPIO banks and
// three PWM timers for the RGB LED
// ******************************

`timescale 1ns/1ns
`include "periph_settings.svh"

module periph_top (
   input  logic                   clk,
   input  logic                   i_arst_n,
   input  wb_pkg::wb_adr_t        i_wb_adr,
   input  wb_pkg::wb_data_t       i_wb_dat,
   input  logic                   i_wb_we,
   input  logic                   i_wb_stb,
   output wb_pkg::wb_data_t       o_wb_rdt,
   output logic                   o_wb_ack,
   output logic                   o_wb_err,
   input  periph_pkg::gpio_word_t i_gpio0_in,
   input  periph_pkg::gpio_word_t i_gpio1_in,
   output periph_pkg::gpio_word_t o_gpio0_out,
   output periph_pkg::gpio_word_t o_gpio0_oe,
   output periph_pkg::gpio_word_t o_gpio1_out,
   output periph_pkg::gpio_word_t o_gpio1_oe,
   output logic [1:0]             o_gpio_irq,
   output logic [`PWM_NUM-1:0]    o_rgb_pwm,
   output logic                   o_pwm_irq
);
   import wb_pkg::*;

   logic [`PWM_NUM-1:0] pwm_irq;

   wb_if slot_bus [`SLOT_NUM] ();

   wb_decoder u_decoder (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .i_wb_adr (i_wb_adr),
      .i_wb_dat (i_wb_dat),
      .i_wb_we  (i_wb_we),
      .i_wb_stb (i_wb_stb),
      .o_wb_rdt (o_wb_rdt),
      .o_wb_ack (o_wb_ack),
      .o_wb_err (o_wb_err),
      .m_slot   (slot_bus)
   );

   // LEDs and switches
   gpio_bank u_gpio0 (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .s_bus    (slot_bus[SLOT_GPIO0]),
      .i_pins   (i_gpio0_in),
      .o_out    (o_gpio0_out),
      .o_oe     (o_gpio0_oe),
      .o_irq    (o_gpio_irq[0])
   );

   // Buttons
   gpio_bank u_gpio1 (
      .clk      (clk),
      .i_arst_n (i_arst_n),
      .s_bus    (slot_bus[SLOT_GPIO1]),
      .i_pins   (i_gpio1_in),
      .o_out    (o_gpio1_out),
      .o_oe     (o_gpio1_oe),
      .o_irq    (o_gpio_irq[1])
   );

   // Red, green, blue
   for (genvar i = 0; i < `PWM_NUM; i++) begin : g_pwm
      pwm_timer u_pwm (
         .clk      (clk),
         .i_arst_n (i_arst_n),
         .s_bus    (slot_bus[SLOT_PWM0 + i]),
         .o_pwm    (o_rgb_pwm[i]),
         .o_irq    (pwm_irq[i])
      );
   end

   // One shared timer interrupt
   assign o_pwm_irq = |pwm_irq;

endmodule

// File: tests/tb_periph.sv
// ******************************
// Peripheral subsystem testbench
// Directed tests of the register bus,
// GPIO banks and PWM timers
// ******************************

`timescale 1ns/1ns
`include "periph_settings.svh"

module tb_periph;
   import wb_pkg::*;
   import periph_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int NUM_TESTS  = 5;

   logic                clk = 1'b0;
   logic                i_arst_n;
   wb_adr_t             i_wb_adr;
   wb_data_t            i_wb_dat;
   logic                i_wb_we;
   logic                i_wb_stb;
   wb_data_t            o_wb_rdt;
   logic                o_wb_ack;
   logic                o_wb_err;
   gpio_word_t          i_gpio0_in;
   gpio_word_t          i_gpio1_in;
   gpio_word_t          o_gpio0_out;
   gpio_word_t          o_gpio0_oe;
   gpio_word_t          o_gpio1_out;
   gpio_word_t          o_gpio1_oe;
   logic [1:0]          o_gpio_irq;
   logic [`PWM_NUM-1:0] o_rgb_pwm;
   logic                o_pwm_irq;

   logic [31:0]         lfsr_q = 32'd32639;
   int                  ack_cycles;
   logic                last_err;

   periph_top u_dut (.*);

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ******************************
   // Helpers
   // ******************************
   // x^32 + x^22 + x^2 + x + 1
   function automatic wb_data_t lfsr_bits(input int n);
      logic     fb;
      wb_data_t r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         r      = {r[30:0], fb};
      end
      return r;
   endfunction

   function automatic wb_adr_t addr(input int slot, input int ofs);
      return wb_adr_t'((slot << `SLOT_LSB) | (ofs << `REG_LSB));
   endfunction

   function automatic gpio_word_t gpio_out(input int b);
      return (b == 0) ? o_gpio0_out : o_gpio1_out;
   endfunction

   function automatic gpio_word_t gpio_oe(input int b);
      return (b == 0) ? o_gpio0_oe : o_gpio1_oe;
   endfunction

   task automatic wait_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic set_pins(input int b, input gpio_word_t v);
      if (b == 0) i_gpio0_in = v;
      else i_gpio1_in = v;
   endtask

   task automatic check_data(input string name, input wb_data_t exp, input wb_data_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         $display("ERRORS FOUND");
         $fatal(1, "data compare failed");
      end
   endtask

   task automatic check_pins(input string name, input gpio_word_t exp, input gpio_word_t act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         $display("ERRORS FOUND");
         $fatal(1, "pin compare failed");
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
         $display("ERRORS FOUND");
         $fatal(1, "bit compare failed");
      end
   endtask

   // ******************************
   // Bus access
   // ******************************
   task automatic bus_cycle(input wb_adr_t a, input logic we, input wb_data_t wd,
                            output wb_data_t rd);
      int n;
      i_wb_adr = a;
      i_wb_we  = we;
      i_wb_dat = wd;
      i_wb_stb = 1'b1;
      n = 0;
      do begin
         wait_cycles(1);
         n++;
      end while (!o_wb_ack && n < 4);
      if (!o_wb_ack) begin
         $display("Bus access to address %h was not acknowledged within 4 cycles", a);
         $display("ERRORS FOUND");
         $fatal(1, "bus timeout");
      end
      rd         = o_wb_rdt;
      last_err   = o_wb_err;
      ack_cycles = n;
      i_wb_stb   = 1'b0;
      i_wb_we    = 1'b0;
      wait_cycles(1);
   endtask

   task automatic wb_write(input wb_adr_t a, input wb_data_t d);
      wb_data_t unused;
      bus_cycle(a, 1'b1, d, unused);
   endtask

   task automatic wb_read(input wb_adr_t a, output wb_data_t d);
      bus_cycle(a, 1'b0, '0, d);
   endtask

   task automatic check_ack(input string name);
      check_data(name, wb_data_t'(1), wb_data_t'(ack_cycles));
      check_bit(name, 1'b0, last_err);
   endtask

   // ******************************
   // Tests
   // ******************************
   task automatic test_reset();
      wb_data_t rd;
      check_bit("reset_wb_ack", 1'b0, o_wb_ack);
      for (int s = 0; s < `SLOT_NUM; s++) begin
         for (int r = 0; r < ((s < 2) ? 5 : 4); r++) begin
            wb_read(addr(s, r), rd);
            check_data("reset_reg", '0, rd);
         end
      end
      for (int b = 0; b < 2; b++) begin
         check_pins("reset_gpio_out", '0, gpio_out(b));
         check_pins("reset_gpio_oe", '0, gpio_oe(b));
      end
      check_bit("reset_gpio_irq", 1'b0, |o_gpio_irq);
      check_bit("reset_rgb_pwm", 1'b0, |o_rgb_pwm);
      check_bit("reset_pwm_irq", 1'b0, o_pwm_irq);
      check_bit("reset_wb_err", 1'b0, o_wb_err);
   endtask

   task automatic test_regs();
      wb_data_t d;
      wb_data_t rd;
      for (int s = 0; s < `SLOT_NUM; s++) begin
         for (int r = 1; r <= 2; r++) begin
            d = lfsr_bits(32);
            wb_write(addr(s, r), d);
            check_ack("reg_write_ack");
            wb_read(addr(s, r), rd);
            check_ack("reg_read_ack");
            check_data("reg_readback", d, rd);
            if (s < 2) begin
               check_pins("reg_gpio_port", gpio_word_t'(d),
                          (r == GPIO_OUT) ? gpio_out(s) : gpio_oe(s));
            end
         end
      end
   endtask

   task automatic test_gpio();
      gpio_word_t pins;
      gpio_word_t mask;
      wb_data_t   rd;
      for (int b = 0; b < 2; b++) begin
         pins = gpio_word_t'(lfsr_bits(32));
         set_pins(b, pins);
         // The read samples GPIO_IN on the third edge after the change
         wait_cycles(2);
         wb_read(addr(b, GPIO_IN), rd);
         check_data("gpio_in", wb_data_t'(pins), rd);
         // Edge interrupt on the chosen pins only
         mask = gpio_word_t'(lfsr_bits(32)) | gpio_word_t'(1);
         set_pins(b, '0);
         wait_cycles(3);
         wb_write(addr(b, GPIO_INTE), wb_data_t'(mask));
         set_pins(b, '1);
         wait_cycles(4);
         wb_read(addr(b, GPIO_ISTAT), rd);
         check_data("gpio_istat_set", wb_data_t'(mask), rd);
         check_data("gpio_irq_set", wb_data_t'(1 << b), wb_data_t'(o_gpio_irq));
         wb_write(addr(b, GPIO_ISTAT), wb_data_t'(mask));
         wb_read(addr(b, GPIO_ISTAT), rd);
         check_data("gpio_istat_clear", '0, rd);
         check_data("gpio_irq_clear", '0, wb_data_t'(o_gpio_irq));
         wb_write(addr(b, GPIO_INTE), '0);
         set_pins(b, '0);
      end
   endtask

   task automatic test_pwm();
      int lrc;
      int hrc;
      int high [`PWM_NUM];
      for (int c = 0; c < `PWM_NUM; c++) begin
         lrc = 4 + int'(lfsr_bits(3));
         hrc = 1 + int'(lfsr_bits(2));
         wb_write(addr(SLOT_PWM0 + c, PWM_LRC), wb_data_t'(lrc));
         wb_write(addr(SLOT_PWM0 + c, PWM_HRC), wb_data_t'(hrc));
         wb_write(addr(SLOT_PWM0 + c, PWM_CNTR), '0);
         wb_write(addr(SLOT_PWM0 + c, PWM_CTRL),
                  wb_data_t'((1 << PWM_CTRL_EN) | (1 << PWM_CTRL_OE)));
         high = '{default: 0};
         // Ten whole periods at any phase
         repeat (10 * (lrc + 1)) begin
            wait_cycles(1);
            for (int k = 0; k < `PWM_NUM; k++) begin
               if (o_rgb_pwm[k]) high[k]++;
            end
         end
         for (int k = 0; k < `PWM_NUM; k++) begin
            check_data("pwm_high_cycles", wb_data_t'((k == c) ? 10 * (lrc + 1 - hrc) : 0),
                       wb_data_t'(high[k]));
         end
         wb_write(addr(SLOT_PWM0 + c, PWM_CTRL), '0);
      end
   endtask

   task automatic test_irq_err();
      wb_data_t rd;
      int       n;
      wb_write(addr(SLOT_PWM0, PWM_LRC), wb_data_t'(7));
      wb_write(addr(SLOT_PWM0, PWM_HRC), wb_data_t'(2));
      wb_write(addr(SLOT_PWM0, PWM_CNTR), '0);
      wb_write(addr(SLOT_PWM0, PWM_CTRL),
               wb_data_t'((1 << PWM_CTRL_EN) | (1 << PWM_CTRL_INTE)));
      check_bit("pwm_irq_early", 1'b0, o_pwm_irq);
      n = 0;
      while (!o_pwm_irq && n < 20) begin
         wait_cycles(1);
         n++;
      end
      check_bit("pwm_irq_rise", 1'b1, o_pwm_irq);
      wb_read(addr(SLOT_PWM0, PWM_CTRL), rd);
      check_data("pwm_ctrl_int", wb_data_t'(4'b1101), rd);
      wb_write(addr(SLOT_PWM0, PWM_CTRL), '0);
      check_bit("pwm_irq_clear", 1'b0, o_pwm_irq);
      for (int s = `SLOT_NUM; s < 8; s++) begin
         wb_write(addr(s, 0), lfsr_bits(32));
         check_bit("err_write", 1'b1, last_err);
         wb_read(addr(s, 1), rd);
         check_bit("err_read", 1'b1, last_err);
         check_data("err_read_data", '0, rd);
      end
   endtask

   initial begin
      i_arst_n   = 1'b0;
      i_wb_adr   = '0;
      i_wb_dat   = '0;
      i_wb_we    = 1'b0;
      i_wb_stb   = 1'b0;
      i_gpio0_in = '0;
      i_gpio1_in = '0;
      repeat (8) @(posedge clk);
      #1;
      i_arst_n = 1'b1;
      wait_cycles(1);
      test_reset();
      test_regs();
      test_gpio();
      test_pwm();
      test_irq_err();
      $display("NO ERRORS");
      $finish;
   end

   // Watchdog
   initial begin
      #(NUM_TESTS * 2000 * CLK_PERIOD);
      $display("Timeout: the tests did not finish in the allowed time");
      $display("ERRORS FOUND");
      $fatal(1, "watchdog expired");
   end

endmodule

// File: sim.f
+incdir+design
design/wb_pkg.sv
design/periph_pkg.sv
design/wb_if.sv
design/wb_decoder.sv
design/gpio_bank.sv
design/pwm_timer.sv
design/periph_top.sv
tests/tb_periph.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the pass line
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing -f sim.f --top-module tb_periph -Mdir obj_dir -o tb_periph &&
{ ./obj_dir/tb_periph > sim.log 2>&1 || true; } &&
grep -q "^NO ERRORS$" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }
